//--- design/mem_io_pkg.sv
`default_nettype none

package mem_io_pkg;

    // Bus word and byte address
    typedef logic [31:0] data_t;
    typedef logic [31:0] addr_t;

    // One write enable per byte lane
    typedef logic [3:0] mask_t;

    // Access width, taken from the low funct3 bits of a load or store
    typedef enum logic [1:0] {
        width_byte = 2'd0,
        width_half = 2'd1,
        width_word = 2'd2
    } width_e;

    // Target of an access after address decode
    typedef enum logic [1:0] {
        region_ram  = 2'd0,
        region_io   = 2'd1,
        region_none = 2'd2
    } region_e;

    // Data RAM geometry
    localparam int RAM_WORDS   = 4096;
    localparam int RAM_INDEX_W = 12;

    // Address bits {31, 30, 28} of a RAM access, base 0x1000_0000
    localparam logic [2:0] RAM_REGION_TAG = 3'b001;
    // Top nibble of the I/O region
    localparam logic [3:0] IO_REGION_TAG = 4'h8;

    // I/O offsets, low address byte
    localparam int IO_OFS_W = 8;
    localparam logic [IO_OFS_W-1:0] CNT_CYCLE_OFS = 8'h10;
    localparam logic [IO_OFS_W-1:0] CNT_LOAD_OFS  = 8'h14;
    localparam logic [IO_OFS_W-1:0] CNT_CLEAR_OFS = 8'h18;
    localparam logic [IO_OFS_W-1:0] CNT_STORE_OFS = 8'h1C;

    // Region of a byte address
    function automatic region_e region_of(addr_t addr);
        region_e r;
        if ({addr[31:30], addr[28]} == RAM_REGION_TAG) begin
            r = region_ram;
        end else if (addr[31:28] == IO_REGION_TAG) begin
            r = region_io;
        end else begin
            r = region_none;
        end
        return r;
    endfunction

endpackage

`default_nettype wire

//--- design/ram_port_if.sv
`timescale 1ns/10ps
`default_nettype none

// One word access into the data RAM
interface ram_port_if;
    import mem_io_pkg::*;

    // Access strobe, one cycle per accepted RAM access
    logic                   en;
    // Zero mask means a read
    mask_t                  we_mask;
    logic [RAM_INDEX_W-1:0] index;
    // Lane aligned store data
    data_t                  wdata;
    // Word read on the edge after en
    data_t                  rdata;

    // Bus side
    modport ctrl (
        output en,
        output we_mask,
        output index,
        output wdata,
        input  rdata
    );

    // Memory side
    modport ram (
        input  en,
        input  we_mask,
        input  index,
        input  wdata,
        output rdata
    );

endinterface

`default_nettype wire

//--- design/store_aligner.sv
`timescale 1ns/10ps
`default_nettype none

module store_aligner (
    input  mem_io_pkg::width_e width,
    input  logic [1:0]         offset,
    input  mem_io_pkg::data_t  wdata,
    output mem_io_pkg::mask_t  mask,
    output mem_io_pkg::data_t  lane_data
);
    import mem_io_pkg::*;

    // Copy the low byte or half into every lane it can land in
    always_comb begin
        case (width)
            width_byte: lane_data = {4{wdata[7:0]}};
            width_half: lane_data = {2{wdata[15:0]}};
            default:    lane_data = wdata;
        endcase
    end

    // Lane enables from width and offset
    always_comb begin
        case (width)
            width_byte: begin
                // Single lane picked by both offset bits
                mask = 4'b0001 << offset;
            end
            width_half: begin
                // Upper or lower half, offset bit 0 ignored
                if (offset[1]) begin
                    mask = 4'b1100;
                end else begin
                    mask = 4'b0011;
                end
            end
            width_word: begin
                mask = 4'b1111;
            end
            default: begin
                // Unused encoding writes nothing
                mask = 4'b0000;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- design/data_ram.sv
`timescale 1ns/10ps
`default_nettype none

module data_ram (
    input logic        clk,
    ram_port_if.ram    port
);
    import mem_io_pkg::*;

    // Word storage
    data_t mem [RAM_WORDS];

    // Byte writes and word read share the enable
    always_ff @(posedge clk) begin
        if (port.en) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (port.we_mask[lane]) begin
                    mem[port.index][lane*8 +: 8] <= port.wdata[lane*8 +: 8];
                end
            end
            // Old contents on a store, unused by the bus side
            port.rdata <= mem[port.index];
        end
    end

endmodule

`default_nettype wire

//--- design/perf_counters.sv
`timescale 1ns/10ps
`default_nettype none

module perf_counters (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              accept,
    input  logic                              we,
    input  logic                              is_io,
    input  logic [mem_io_pkg::IO_OFS_W-1:0]   offset,
    output mem_io_pkg::data_t                 rdata
);
    import mem_io_pkg::*;

    data_t cycle_count;
    data_t load_count;
    data_t store_count;
    logic  clear;

    // Store to the clear offset wipes every counter
    assign clear = accept && we && is_io && (offset == CNT_CLEAR_OFS);

    // Free running cycle count
    always_ff @(posedge clk) begin
        if (rst || clear) begin
            cycle_count <= '0;
        end else begin
            cycle_count <= cycle_count + 1'b1;
        end
    end

    // Accepted accesses of any region
    always_ff @(posedge clk) begin
        if (rst || clear) begin
            load_count  <= '0;
            store_count <= '0;
        end else if (accept) begin
            if (we) begin
                store_count <= store_count + 1'b1;
            end else begin
                load_count <= load_count + 1'b1;
            end
        end
    end

    // Sampled at accept, value before this access counts
    always_ff @(posedge clk) begin
        if (accept && is_io && !we) begin
            case (offset)
                CNT_CYCLE_OFS: rdata <= cycle_count;
                CNT_LOAD_OFS:  rdata <= load_count;
                CNT_STORE_OFS: rdata <= store_count;
                default:       rdata <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/load_extender.sv
`timescale 1ns/10ps
`default_nettype none

module load_extender (
    input  mem_io_pkg::data_t  word,
    input  mem_io_pkg::width_e width,
    input  logic               is_unsigned,
    input  logic [1:0]         offset,
    output mem_io_pkg::data_t  value
);
    import mem_io_pkg::*;

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;
    logic        fill;

    // Byte lane from both offset bits
    always_comb begin
        case (offset)
            2'd0:    byte_sel = word[7:0];
            2'd1:    byte_sel = word[15:8];
            2'd2:    byte_sel = word[23:16];
            default: byte_sel = word[31:24];
        endcase
    end

    // Half lane from offset bit 1 only
    assign half_sel = offset[1] ? word[31:16] : word[15:0];

    // Extension bit, sign of the selected part or zero
    always_comb begin
        case (width)
            width_byte: fill = !is_unsigned && byte_sel[7];
            width_half: fill = !is_unsigned && half_sel[15];
            default:    fill = 1'b0;
        endcase
    end

    always_comb begin
        case (width)
            width_byte: value = {{24{fill}}, byte_sel};
            width_half: value = {{16{fill}}, half_sel};
            // Whole word unchanged
            default:    value = word;
        endcase
    end

endmodule

`default_nettype wire

//--- design/mem_io_top.sv
`timescale 1ns/10ps
`default_nettype none

module mem_io_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               cyc,
    input  logic               stb,
    input  logic               we,
    input  mem_io_pkg::addr_t  adr,
    input  mem_io_pkg::data_t  dat_w,
    input  mem_io_pkg::width_e width,
    input  logic               is_unsigned,
    output mem_io_pkg::data_t  dat_r,
    output logic               ack
);
    import mem_io_pkg::*;

    region_e    region;
    logic       accept;
    mask_t      st_mask;
    data_t      st_data;
    data_t      cnt_rdata;

    // State held for the ack cycle
    region_e    region_q;
    width_e     width_q;
    logic       unsigned_q;
    logic [1:0] offset_q;
    data_t      read_word;

    ram_port_if rp ();

    // Region of the current request
    assign region = region_of(adr);

    // New request while no ack pending
    assign accept = cyc && stb && !ack;

    // Single cycle ack after every accept
    always_ff @(posedge clk) begin
        if (rst) begin
            ack <= 1'b0;
        end else begin
            ack <= accept;
        end
    end

    // Byte lanes and mask of a store
    store_aligner u_store_aligner (
        .width     (width),
        .offset    (adr[1:0]),
        .wdata     (dat_w),
        .mask      (st_mask),
        .lane_data (st_data)
    );

    // RAM only sees accesses to its own region
    assign rp.en      = accept && (region == region_ram);
    assign rp.we_mask = (we && region == region_ram) ? st_mask : '0;
    assign rp.index   = adr[RAM_INDEX_W+1:2];
    assign rp.wdata   = st_data;

    data_ram u_data_ram (
        .clk  (clk),
        .port (rp.ram)
    );

    perf_counters u_perf_counters (
        .clk    (clk),
        .rst    (rst),
        .accept (accept),
        .we     (we),
        .is_io  (region == region_io),
        .offset (adr[IO_OFS_W-1:0]),
        .rdata  (cnt_rdata)
    );

    // Source of read data for the next cycle
    // Stores and idle cycles select nothing, so dat_r reads zero
    always_ff @(posedge clk) begin
        if (rst) begin
            region_q <= region_none;
        end else if (accept && !we) begin
            region_q <= region;
        end else begin
            region_q <= region_none;
        end
    end

    // Tags of the accepted load
    always_ff @(posedge clk) begin
        if (accept) begin
            width_q    <= width;
            unsigned_q <= is_unsigned;
            offset_q   <= adr[1:0];
        end
    end

    // Raw word ahead of extension
    always_comb begin
        case (region_q)
            region_ram: read_word = rp.rdata;
            region_io:  read_word = cnt_rdata;
            default:    read_word = '0;
        endcase
    end

    load_extender u_load_extender (
        .word        (read_word),
        .width       (width_q),
        .is_unsigned (unsigned_q),
        .offset      (offset_q),
        .value       (dat_r)
    );

endmodule

`default_nettype wire

//--- test/tb_mem_io.sv
`timescale 1ns/10ps
`default_nettype none

module tb_mem_io;
    import mem_io_pkg::*;

    localparam int    MAX_VECTORS = 64;
    localparam addr_t RAND_ADR    = 32'h1000_0020;
    localparam addr_t LANE_ADR    = 32'h1000_0024;

    logic   clk;
    logic   rst;
    logic   cyc;
    logic   stb;
    logic   we;
    addr_t  adr;
    data_t  dat_w;
    width_e width;
    logic   is_unsigned;
    data_t  dat_r;
    logic   ack;

    // Vector table, filled before reset ends
    string      vec_name   [MAX_VECTORS];
    logic       vec_we     [MAX_VECTORS];
    logic [1:0] vec_width  [MAX_VECTORS];
    logic       vec_uns    [MAX_VECTORS];
    addr_t      vec_adr    [MAX_VECTORS];
    data_t      vec_wdata  [MAX_VECTORS];
    data_t      vec_expect [MAX_VECTORS];
    int         num_vectors;

    int pass_count;
    int fail_count;
    int cycle_count = 0;
    int cycle_limit = 0;

    mem_io_top u_dut (
        .clk         (clk),
        .rst         (rst),
        .cyc         (cyc),
        .stb         (stb),
        .we          (we),
        .adr         (adr),
        .dat_w       (dat_w),
        .width       (width),
        .is_unsigned (is_unsigned),
        .dat_r       (dat_r),
        .ack         (ack)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Cycle budget, armed once the vector count is known
    initial begin
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("*** TEST FAILED ***");
        $finish;
    end

    task automatic read_vectors();
        int    fd;
        int    n;
        int    op;
        int    w;
        int    u;
        string line;
        string name;
        addr_t a;
        data_t d;
        data_t e;
        fd = $fopen("test/mem_io_vectors.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the vector file test/mem_io_vectors.txt");
            fail_count++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                // Skip blanks and the column notes
                if (n > 0 && line.len() > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%s %h %h %h %h %h %h", name, op, w, u, a, d, e);
                    if (n == 7 && num_vectors < MAX_VECTORS) begin
                        vec_name[num_vectors]   = name;
                        vec_we[num_vectors]     = (op != 0);
                        vec_width[num_vectors]  = w[1:0];
                        vec_uns[num_vectors]    = (u != 0);
                        vec_adr[num_vectors]    = a;
                        vec_wdata[num_vectors]  = d;
                        vec_expect[num_vectors] = e;
                        num_vectors++;
                    end
                end
            end
            $fclose(fd);
            if (num_vectors == 0) begin
                $display("No vectors were read from the vector file");
                fail_count++;
            end
        end
    endtask

    // One classic cycle, starts and ends 2 ns after a rising edge
    // Three cycles per access: request, ack, idle
    task automatic bus_access(input logic wr, input width_e w, input logic u, input addr_t a,
                              input data_t d, output data_t rd, output logic ack_ok);
        ack_ok = (ack === 1'b0);
        cyc = 1'b1;
        stb = 1'b1;
        we = wr;
        adr = a;
        dat_w = d;
        width = w;
        is_unsigned = u;
        // Accept edge
        @(posedge clk);
        #2;
        if (ack !== 1'b1) begin
            ack_ok = 1'b0;
        end
        rd = dat_r;
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
        @(posedge clk);
        #2;
        // Ack lasts one cycle only
        if (ack !== 1'b0) begin
            ack_ok = 1'b0;
        end
        @(posedge clk);
        #2;
    endtask

    task automatic report_result(input string name, input logic ok);
        if (ok) begin
            pass_count++;
            $display("PASS %s", name);
        end else begin
            fail_count++;
            $display("FAIL %s", name);
        end
    endtask

    task automatic run_test(input string name, input logic wr, input width_e w, input logic u,
                            input addr_t a, input data_t d, input data_t exp);
        data_t rd;
        logic  ack_ok;
        logic  ok;
        bus_access(wr, w, u, a, d, rd, ack_ok);
        ok = 1'b1;
        if (!ack_ok) begin
            $display("%s: ack was not high for exactly the one cycle after acceptance", name);
            ok = 1'b0;
        end
        // Reads only, stores return nothing
        if (!wr && rd !== exp) begin
            $display("Mismatch %s: expected %08h, actual %08h", name, exp, rd);
            ok = 1'b0;
        end
        report_result(name, ok);
    endtask

    task automatic check_reset();
        logic ok;
        ok = 1'b1;
        if (ack !== 1'b0) begin
            $display("reset_state: ack is not low after reset");
            ok = 1'b0;
        end
        if (dat_r !== 32'h0) begin
            $display("Mismatch reset_state: expected %08h, actual %08h", 32'h0, dat_r);
            ok = 1'b0;
        end
        report_result("reset_state", ok);
    endtask

    // Random word, then a byte patched into lane 2
    task automatic random_word_test();
        data_t rnd;
        data_t rd;
        data_t exp;
        logic  ack_ok;
        logic  ok;
        ok = 1'b1;
        rnd = $urandom;
        exp = {rnd[31:24], 8'h5A, rnd[15:0]};
        bus_access(1'b1, width_word, 1'b0, RAND_ADR, rnd, rd, ack_ok);
        ok = ok && ack_ok;
        bus_access(1'b1, width_byte, 1'b0, RAND_ADR + 2, 32'h0000_005A, rd, ack_ok);
        ok = ok && ack_ok;
        bus_access(1'b0, width_word, 1'b0, RAND_ADR, 32'h0, rd, ack_ok);
        ok = ok && ack_ok;
        if (!ok) begin
            $display("rand_word: ack was not high for exactly the one cycle after acceptance");
        end
        if (rd !== exp) begin
            $display("Mismatch rand_word: expected %08h, actual %08h", exp, rd);
            ok = 1'b0;
        end
        report_result("rand_word", ok);
    endtask

    // Lower half lanes, byte lane 2 and an unused I/O offset
    // Lanes hold 5A 96 C3 A5 so a wrong lane shows
    task automatic lane_select_tests();
        run_test("lane_w_store", 1'b1, width_word, 1'b0, LANE_ADR, 32'h5A96_F00F, 32'h0);
        // Upper half of the store data must be dropped
        run_test("h_st_o0", 1'b1, width_half, 1'b0, LANE_ADR, 32'hFFFF_C3A5, 32'h0);
        run_test("merge_load4", 1'b0, width_word, 1'b0, LANE_ADR, 32'h0, 32'h5A96_C3A5);
        run_test("lh_s_o0", 1'b0, width_half, 1'b0, LANE_ADR, 32'h0, 32'hFFFF_C3A5);
        run_test("lhu_o0", 1'b0, width_half, 1'b1, LANE_ADR, 32'h0, 32'h0000_C3A5);
        run_test("lb_s_o2", 1'b0, width_byte, 1'b0, LANE_ADR + 2, 32'h0, 32'hFFFF_FF96);
        run_test("lbu_o2", 1'b0, width_byte, 1'b1, LANE_ADR + 2, 32'h0, 32'h0000_0096);
        // No counter behind offset 0
        run_test("io_unused_ofs", 1'b0, width_word, 1'b0, 32'h8000_0000, 32'h0, 32'h0);
    endtask

    initial begin
        rst = 1'b1;
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
        adr = '0;
        dat_w = '0;
        width = width_word;
        is_unsigned = 1'b0;
        pass_count = 0;
        fail_count = 0;
        num_vectors = 0;
        void'($urandom(36257));
        read_vectors();
        cycle_limit = 4 * num_vectors + 50;
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;
        check_reset();
        for (int i = 0; i < num_vectors; i++) begin
            run_test(vec_name[i], vec_we[i], width_e'(vec_width[i]), vec_uns[i],
                     vec_adr[i], vec_wdata[i], vec_expect[i]);
        end
        random_word_test();
        lane_select_tests();
        $display("Tests: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- test/mem_io_vectors.txt
# name op(0 read, 1 write) width(0 byte, 1 half, 2 word) unsigned address wdata expected
# all numbers hex, expected is checked on reads only
w_store0     1 2 0 10000000 12345678 00000000
w_load0      0 2 0 10000000 00000000 12345678
w_store1     1 2 0 10000004 00000000 00000000
b_st_o1      1 0 0 10000005 000000AB 00000000
b_st_o2      1 0 0 10000006 123456CD 00000000
merge_load1  0 2 0 10000004 00000000 00CDAB00
w_store2     1 2 0 10000008 FFFFFFFF 00000000
h_st_o2      1 1 0 1000000A 00008001 00000000
merge_load2  0 2 0 10000008 00000000 8001FFFF
w_store3     1 2 0 1000000C 00000000 00000000
b_st_o0      1 0 0 1000000C 0000007F 00000000
b_st_o3      1 0 0 1000000F 00000080 00000000
merge_load3  0 2 0 1000000C 00000000 8000007F
lb_s_o0      0 0 0 1000000C 00000000 0000007F
lb_s_o3      0 0 0 1000000F 00000000 FFFFFF80
lbu_o3       0 0 1 1000000F 00000000 00000080
lh_s_o2      0 1 0 1000000A 00000000 FFFF8001
lhu_o2       0 1 1 1000000A 00000000 00008001
lbu_o1       0 0 1 10000005 00000000 000000AB
unmap_load   0 2 0 20000000 00000000 00000000
unmap_store  1 2 0 20000000 DEADBEEF 00000000
ram_kept     0 2 0 10000000 00000000 12345678
cnt_clear    1 2 0 80000018 00000000 00000000
st_a         1 2 0 10000010 11111111 00000000
ld_a         0 2 0 10000010 00000000 11111111
ld_b         0 1 1 10000012 00000000 00001111
ld_c         0 0 0 10000013 00000000 00000011
st_b         1 0 0 10000014 000000EE 00000000
cnt_load     0 2 0 80000014 00000000 00000003
cnt_store    0 2 0 8000001C 00000000 00000002
cnt_load2    0 2 0 80000014 00000000 00000005
cyc_read1    0 2 0 80000010 00000000 0000001A
cyc_read2    0 2 0 80000010 00000000 0000001D

//--- list.f
design/mem_io_pkg.sv
design/ram_port_if.sv
design/store_aligner.sv
design/data_ram.sv
design/perf_counters.sv
design/load_extender.sv
design/mem_io_top.sv
test/tb_mem_io.sv

//--- run.sh
#!/bin/sh
# Compile with Verilator, run the testbench, then scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_mem_io -f list.f -o tb_mem_io \
    || { echo "Verilator build failed"; exit 1; }
./obj_dir/tb_mem_io > sim.log 2>&1 || echo "Simulation exited with an error" >> sim.log
cat sim.log
# A missing summary line also counts as a failure
grep -qF "*** TEST FAILED ***" sim.log && exit 1 || grep -qF "Tests:" sim.log || exit 1
exit 0
